//--- hdl/fsqrt_pkg.sv
package fsqrt_pkg;

  // ieee single fields.
  localparam int EXP_W = 8;
  localparam int FRAC_W = 23;

  // mantissa in q2.23, lies in [1,4) once the exponent is made even.
  localparam int MANT_W = 25;

  // reciprocal square root estimate in q1.27.
  localparam int EST_W = 28;

  localparam int SEED_BITS = 5;
  localparam int SEED_DEPTH = 32;
  localparam int NR_STEPS = 3;

  // mantissa times estimate, q3.50.
  localparam int ROOT_W = MANT_W + EST_W;

  localparam logic [EXP_W-1:0] EXP_BIAS_HALF = 8'd64;

  // result queue entries, also the input credits held after reset.
  localparam int QUEUE_DEPTH = 8;
  // two extra bits leave room for downstream credits beyond the queue depth.
  localparam int CNT_W = $clog2(QUEUE_DEPTH) + 2;

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [FRAC_W-1:0] frac;
  } fp32_t;

  typedef struct packed {
    logic              special;     // result fixed by the special-case rule.
    fp32_t             special_val;
    logic [MANT_W-1:0] mant;
    logic [EXP_W-1:0]  exp_half;    // biased exponent of a root in [1,2).
  } dec_t;

  typedef struct packed {
    dec_t             dec;
    logic [EST_W-1:0] est;
  } nr_t;

  // 1/sqrt of each bin midpoint, indexed by mant[24:20].
  // entries below 8 are never reached since the mantissa is at least 1.
  localparam logic [EST_W-1:0] seed_table [SEED_DEPTH] = '{
    28'h8000000, 28'h8000000, 28'h8000000, 28'h8000000,
    28'h8000000, 28'h8000000, 28'h8000000, 28'h8000000,
    28'h7C2F000, 28'h7576000, 28'h6FBA000, 28'h6AC3000,
    28'h6666000, 28'h6289000, 28'h5F14000, 28'h5BF6000,
    28'h5921000, 28'h568B000, 28'h542C000, 28'h51FC000,  // m in [2,2.5).
    28'h4FF6000, 28'h4E14000, 28'h4C53000, 28'h4AAF000,
    28'h4925000, 28'h47B2000, 28'h4654000, 28'h450A000,
    28'h43D1000, 28'h42A8000, 28'h418E000, 28'h4082000
  };

endpackage

//--- hdl/fsqrt_decode.sv
module fsqrt_decode import fsqrt_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  fp32_t in_data,
  output logic  dec_valid,
  output dec_t  dec
);

  logic       is_nan;
  logic       is_pinf;
  logic       is_zero;
  logic       is_neg;
  logic [4:0] sub_shift;
  dec_t       dec_next;

  assign is_nan  = (in_data.exp == '1) && (in_data.frac != '0);
  assign is_pinf = !in_data.sign && (in_data.exp == '1) && (in_data.frac == '0);
  assign is_zero = (in_data.exp == '0) && (in_data.frac == '0);
  assign is_neg  = in_data.sign;

  // even left shift that puts the leading one of a subnormal fraction at bit 23 or 24.
  always_comb begin
    sub_shift = 5'(MANT_W - 1);
    for (int i = 0; i < FRAC_W; i++) begin
      if (in_data.frac[i]) begin
        sub_shift = 5'((MANT_W - 1 - i) & ~1);
      end
    end
  end

  always_comb begin
    dec_next.special = is_nan | is_pinf | is_zero | is_neg;

    if (is_nan) begin
      // quieted, sign and payload kept.
      dec_next.special_val = {in_data.sign, {EXP_W{1'b1}}, 1'b1, in_data.frac[FRAC_W-2:0]};
    end else if (is_pinf) begin
      dec_next.special_val = {1'b0, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
    end else if (is_zero) begin
      dec_next.special_val = {in_data.sign, {EXP_W{1'b0}}, {FRAC_W{1'b0}}};
    end else begin
      dec_next.special_val = {1'b1, {EXP_W{1'b1}}, 1'b1, {(FRAC_W-1){1'b0}}};
    end

    if (in_data.exp != '0) begin
      // an even biased exponent is odd unbiased, so it moves one into the mantissa.
      dec_next.mant = in_data.exp[0] ? {2'b01, in_data.frac} : {1'b1, in_data.frac, 1'b0};
      dec_next.exp_half = {1'b0, in_data.exp[EXP_W-1:1]} + EXP_BIAS_HALF
                          - EXP_W'(!in_data.exp[0]);
    end else begin
      dec_next.mant = {2'b00, in_data.frac} << sub_shift;
      dec_next.exp_half = EXP_BIAS_HALF - EXP_W'(sub_shift[4:1]);  // -63 - shift/2, biased.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    dec <= dec_next;
  end

endmodule

//--- hdl/fsqrt_newton_step.sv
module fsqrt_newton_step import fsqrt_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  nr_t  in_op,
  output logic out_valid,
  output nr_t  out_op
);

  logic [2*EST_W-1:0]      sq;     // y*y, q2.54.
  logic [MANT_W+EST_W+3:0] msq;    // m*y*y, q4.53.
  logic [MANT_W+EST_W+3:0] corr;
  logic [2*EST_W+3:0]      prod;   // q3.57.
  logic [EST_W-1:0]        est_next;

  // y' = y * (3 - m*y*y) / 2.
  assign sq   = in_op.est * in_op.est;
  assign msq  = in_op.dec.mant * sq[2*EST_W-1 -: EST_W+4];
  assign corr = {4'd3, {(MANT_W+EST_W){1'b0}}} - msq;
  assign prod = in_op.est * corr[MANT_W+EST_W+1 -: EST_W+4];

  // the halving is folded into the bit select.
  assign est_next = prod[2*EST_W+2 -: EST_W] + EST_W'(prod[EST_W+2]);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    out_op.dec <= in_op.dec;
    out_op.est <= est_next;
  end

  // a zero estimate from the seed table or an earlier step never recovers.
  a_est_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_op.dec.special |-> in_op.est != '0)
    else $error("newton step received a zero estimate");

endmodule

//--- hdl/fsqrt_result.sv
module fsqrt_result import fsqrt_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  nr_t   in_op,
  output logic  res_valid,
  output fp32_t res
);

  logic [ROOT_W-1:0] root;
  logic [ROOT_W-1:0] norm;
  logic [EXP_W-1:0]  exp_norm;
  logic [EXP_W-1:0]  exp_fin;
  logic [FRAC_W:0]   sig;
  logic              rnd;
  logic [FRAC_W+1:0] sig_rnd;
  logic [FRAC_W-1:0] frac_fin;
  fp32_t             res_next;

  // sqrt(m) = m * (1/sqrt(m)), q3.50 with 1.0 at bit 50.
  assign root = in_op.dec.mant * in_op.est;

  // the root is close to [1,2), but the estimate can leave it just outside.
  always_comb begin
    if (root[ROOT_W-2]) begin
      norm     = root;
      exp_norm = in_op.dec.exp_half + 8'd1;
    end else if (root[ROOT_W-3]) begin
      norm     = root << 1;
      exp_norm = in_op.dec.exp_half;
    end else begin
      norm     = root << 2;
      exp_norm = in_op.dec.exp_half - 8'd1;
    end
  end

  assign sig     = norm[ROOT_W-2 -: FRAC_W+1];
  assign rnd     = norm[ROOT_W-FRAC_W-3];
  assign sig_rnd = {1'b0, sig} + (FRAC_W+2)'(rnd);

  // rounding up from all ones carries into the exponent.
  always_comb begin
    if (sig_rnd[FRAC_W+1]) begin
      frac_fin = sig_rnd[FRAC_W:1];
      exp_fin  = exp_norm + 8'd1;
    end else begin
      frac_fin = sig_rnd[FRAC_W-1:0];
      exp_fin  = exp_norm;
    end
  end

  always_comb begin
    if (in_op.dec.special) begin
      res_next = in_op.dec.special_val;
    end else begin
      res_next = {1'b0, exp_fin, frac_fin};  // root of a positive operand.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    res <= res_next;
  end

endmodule

//--- hdl/fsqrt_result_queue.sv
module fsqrt_result_queue import fsqrt_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr_valid,
  input  fp32_t wr_data,
  input  logic  out_credit,
  output logic  out_valid,
  output fp32_t out_data,
  output logic  in_credit
);

  // pointers wrap on their own, the depth is a power of two.
  fp32_t                          mem [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
  logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
  logic [CNT_W-1:0]               count;
  logic [CNT_W-1:0]               credit_cnt;
  logic                           pop;

  assign pop = (count != '0) && (credit_cnt != '0);

  assign out_valid = pop;
  assign out_data  = mem[rd_ptr];
  assign in_credit = pop;  // the freed slot goes back upstream.

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_cnt <= '0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count      <= count + CNT_W'(wr_valid) - CNT_W'(pop);
      credit_cnt <= credit_cnt + CNT_W'(out_credit) - CNT_W'(pop);
    end
  end

  // upstream credits cover the whole pipeline, so a write never finds the queue full.
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid |-> count < CNT_W'(QUEUE_DEPTH))
    else $error("result queue written while full");

  a_credit_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    out_credit && !pop |-> credit_cnt != '1)
    else $error("output credit counter wrapped");

endmodule

//--- hdl/fsqrt_top.sv
module fsqrt_top import fsqrt_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  fp32_t in_data,
  output logic  in_credit,
  output logic  out_valid,
  output fp32_t out_data,
  input  logic  out_credit
);

  logic                 dec_valid;
  dec_t                 dec;
  logic [SEED_BITS-1:0] seed_idx;
  logic [NR_STEPS:0]    nr_valid;
  nr_t                  nr_op [NR_STEPS+1];
  logic                 res_valid;
  fp32_t                res;

  fsqrt_decode decode_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  // seed lookup sits between the decode register and the first step.
  assign seed_idx    = dec.mant[MANT_W-1 -: SEED_BITS];
  assign nr_valid[0] = dec_valid;
  assign nr_op[0]    = '{dec: dec, est: seed_table[seed_idx]};

  for (genvar g = 0; g < NR_STEPS; g++) begin : g_newton
    fsqrt_newton_step newton_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (nr_valid[g]),
      .in_op     (nr_op[g]),
      .out_valid (nr_valid[g+1]),
      .out_op    (nr_op[g+1])
    );
  end

  fsqrt_result result_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (nr_valid[NR_STEPS]),
    .in_op     (nr_op[NR_STEPS]),
    .res_valid (res_valid),
    .res       (res)
  );

  fsqrt_result_queue queue_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid   (res_valid),
    .wr_data    (res),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .in_credit  (in_credit)
  );

endmodule

//--- tb/fsqrt_ref.svh
`ifndef FSQRT_REF_SVH
`define FSQRT_REF_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// value of a single-precision pattern, subnormals included.
function automatic real fp_value(input logic [31:0] b);
  real m;
  int  e;
  m = real'(b[22:0]);
  e = int'(b[30:23]);
  if (e == 0) begin
    e = 1;
  end else begin
    m = m + 8388608.0;  // hidden one.
  end
  m = m * (2.0 ** (e - 150));
  return b[31] ? -m : m;
endfunction

function automatic logic [31:0] special_root(input logic [31:0] x);
  if (x[30:23] == 8'hFF && x[22:0] != 23'd0) begin
    return {x[31], 8'hFF, 1'b1, x[21:0]};  // quiet, payload kept.
  end
  if (x[30:0] == 31'd0) begin
    return x;
  end
  if (x[31]) begin
    return 32'hFFC00000;
  end
  return 32'h7F800000;
endfunction

// squared root must land within two ulp of the operand.
function automatic logic root_close(input logic [31:0] x, input logic [31:0] r);
  real xv;
  real rv;
  real tol;
  if (r[31] || r[30:23] == 8'h00 || r[30:23] == 8'hFF) begin
    return 1'b0;
  end
  xv  = fp_value(x);
  rv  = fp_value(r);
  tol = xv * (2.0 ** (-22));
  return (rv * rv - xv <= tol) && (xv - rv * rv <= tol);
endfunction

`endif

//--- tb/fsqrt_tb.sv
module fsqrt_tb import fsqrt_pkg::*; ();

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int HOLD_OPS    = 4;
  localparam int EXACT_OPS   = 7;
  localparam int SPECIAL_OPS = 9;
  localparam int RANDOM_OPS  = 200;
  localparam int FLOW_OPS    = 32;
  localparam int THRU_OPS    = 32;
  localparam int TOTAL_OPS   = HOLD_OPS + EXACT_OPS + SPECIAL_OPS + RANDOM_OPS + FLOW_OPS
                               + THRU_OPS;
  localparam int CYCLE_LIMIT = TOTAL_OPS * 20 + 200;

  typedef struct packed {
    logic [31:0] op;
    logic [31:0] want;
    logic        exact;  // bit-exact compare, otherwise the square is checked.
  } item_t;

  logic  clk;
  logic  rst_n;
  logic  in_valid;
  fp32_t in_data;
  logic  in_credit;
  logic  out_valid;
  fp32_t out_data;
  logic  out_credit;

  item_t       exp_q[$];
  item_t       head;
  logic        head_valid = 1'b0;
  int          in_credits;
  int          accepted = 0;
  int          granted = 0;
  int          outputs = 0;
  int          returned = 0;
  int          errors = 0;
  int          err_mark = 0;
  int          tests = 0;
  int          cycles = 0;
  int          run_len = 0;
  int          max_run = 0;
  int          credit_mode = 0;  // 0 none, 1 cover every accepted input, 2 random bursts.
  int          rand_count = 0;
  logic [31:0] rng = 32'd47;

  `include "fsqrt_ref.svh"

  fsqrt_top fsqrt_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_credit (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic result_ok(input item_t it, input logic [31:0] r);
    return it.exact ? (r == it.want) : root_close(it.op, r);
  endfunction

  task automatic report_value(input item_t it, input logic [31:0] r);
    if (it.exact) begin
      $display("Fail out_data: got %h, expected %h for input %h", r, it.want, it.op);
    end else begin
      $display("Fail out_data: got %h for input %h, square not within 2 ulp", r, it.op);
    end
  endtask

  task automatic refresh_head();
    head_valid = exp_q.size() != 0;
    head = head_valid ? exp_q[0] : '0;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d results still pending", cycles, exp_q.size());
      $display("tests failed");
      $finish;
    end else if (rst_n) begin
      if (in_valid) accepted++;
      if (out_credit) granted++;
      if (in_credit) begin
        returned++;
        in_credits++;
      end
      if (out_valid) begin
        outputs++;
        run_len++;
        if (run_len > max_run) max_run = run_len;
        if (exp_q.size() != 0) void'(exp_q.pop_front());
        refresh_head();
      end else begin
        run_len = 0;
      end
    end
  end

  a_result_value: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && head_valid |-> result_ok(head, out_data))
    else begin
      errors++;
      report_value($sampled(head), $sampled(out_data));
    end

  a_result_expected: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> head_valid)
    else begin
      errors++;
      $display("a result appeared with no input pending");
    end

  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> outputs < granted)
    else begin
      errors++;
      $display("more results than output credits granted");
    end

  a_hold_without_credit: assert property (@(posedge clk) disable iff (!rst_n)
    granted == 0 |-> !out_valid && !in_credit)
    else begin
      errors++;
      $display("result or credit return before any output credit");
    end

  a_credit_return: assert property (@(posedge clk) disable iff (!rst_n)
    in_credit == out_valid)
    else begin
      errors++;
      $display("input credit returned out of step with a result");
    end

  // output credits, driven with the same delay as the other inputs.
  initial begin
    logic [31:0] crng;
    int          burst_left;
    logic        burst_on;
    crng = 32'd47;
    burst_left = 0;
    burst_on = 1'b0;
    out_credit = 1'b0;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (credit_mode == 1) begin
        out_credit = accepted > granted;
      end else if (credit_mode == 2) begin
        if (burst_left == 0) begin
          crng = xorshift32(crng);
          burst_on = crng[0];
          burst_left = 1 + int'(crng[4:1]);
        end
        burst_left--;
        out_credit = burst_on && (accepted > granted);
      end else begin
        out_credit = 1'b0;
      end
    end
  end

  task automatic send_op(input logic [31:0] op, input logic [31:0] want, input logic exact);
    item_t it;
    it = '{op: op, want: want, exact: exact};
    while (in_credits == 0) begin
      in_valid = 1'b0;
      @(posedge clk);
      #DRIVE_DELAY;
    end
    in_valid = 1'b1;
    in_data = op;
    in_credits--;
    exp_q.push_back(it);
    refresh_head();
    @(posedge clk);
    #DRIVE_DELAY;
    in_valid = 1'b0;
  endtask

  task automatic send_special(input logic [31:0] op);
    send_op(op, special_root(op), 1'b1);
  endtask

  // positive operand, every eighth one subnormal.
  task automatic send_random();
    logic [7:0]  e;
    logic [22:0] f;
    rng = xorshift32(rng);
    e = rng[30:23];
    if (e == 8'hFF) e = 8'hFE;
    if (rand_count % 8 == 0) e = 8'h00;
    f = rng[22:0];
    if (e == 8'h00 && f == 23'd0) f = 23'd1;
    rand_count++;
    send_op({1'b0, e, f}, 32'h0, 1'b0);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) wait_cycles(1);
    wait_cycles(2);
  endtask

  task automatic end_test(input string name);
    drain();
    assert (returned == outputs) else begin
      errors++;
      $display("%0d input credits returned for %0d results", returned, outputs);
    end
    tests++;
    if (errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    int held;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_data = '0;
    in_credits = QUEUE_DEPTH;
    repeat (3) @(posedge clk);
    #DRIVE_DELAY rst_n = 1'b1;

    for (int i = 0; i < HOLD_OPS; i++) send_random();
    wait_cycles(12);
    credit_mode = 1;
    end_test("hold without credits");

    send_op(32'h3F800000, 32'h3F800000, 1'b1);  // 1.0.
    send_op(32'h40800000, 32'h40000000, 1'b1);
    send_op(32'h41100000, 32'h40400000, 1'b1);
    send_op(32'h3E800000, 32'h3F000000, 1'b1);
    send_op(32'h7E800000, 32'h5F000000, 1'b1);  // 2^126.
    send_op(32'h00000002, 32'h1A800000, 1'b1);  // 2^-148, root 2^-74.
    send_op(32'h4B800000, 32'h45800000, 1'b1);
    end_test("exact roots");

    send_special(32'h00000000);
    send_special(32'h80000000);
    send_special(32'h7F800000);
    send_special(32'h7FA12345);
    send_special(32'hFF812345);
    send_special(32'h7FC00001);
    send_special(32'hFF800000);
    send_special(32'hBF800000);
    send_special(32'h80000005);
    end_test("special operands");

    for (int i = 0; i < RANDOM_OPS; i++) send_random();
    end_test("random operands");

    credit_mode = 0;
    for (int i = 0; i < QUEUE_DEPTH; i++) send_random();
    held = outputs;
    wait_cycles(12);
    assert (outputs == held && in_credits == 0) else begin
      errors++;
      $display("results left the queue while output credits were withheld");
    end
    credit_mode = 2;
    for (int i = QUEUE_DEPTH; i < FLOW_OPS; i++) send_random();
    end_test("back-pressure and order");

    credit_mode = 1;
    max_run = 0;
    for (int i = 0; i < THRU_OPS; i++) send_random();
    drain();
    assert (max_run >= THRU_OPS) else begin
      errors++;
      $display("results did not stream one per cycle, longest run %0d", max_run);
    end
    end_test("throughput");

    $display("%0d tests run, %0d checks failed", tests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+tb
hdl/fsqrt_pkg.sv
hdl/fsqrt_decode.sv
hdl/fsqrt_newton_step.sv
hdl/fsqrt_result.sv
hdl/fsqrt_result_queue.sv
hdl/fsqrt_top.sv
tb/fsqrt_tb.sv
